/* smc_defines.svh */
`ifndef SMC_DEFINES_SVH
`define SMC_DEFINES_SVH

// ------------------------------
// Bus widths
// ------------------------------

// AHB side
`define SMC_HADDR_W 32
`define SMC_HDATA_W 32

// External SRAM side, one 16-bit bank
`define SMC_EMI_DATA_W 16
`define SMC_EMI_ADDR_W 32
`define SMC_EMI_BE_W 2

// ------------------------------
// Strobe timing in hclk cycles
// ------------------------------

// Chip select lead before the strobe
`define SMC_CSLE_CYCLES 1
// Wait states, strobe is one cycle longer
`define SMC_WS_CYCLES 2
// Bus float time after the strobe
`define SMC_CSTE_CYCLES 1
// Width of each timing counter
`define SMC_CNT_W 4

`endif

/* smc_pkg.sv */
package smc_pkg;

  // ------------------------------
  // Sequencer states
  // ------------------------------

  typedef enum logic [1:0] {
    IDLE   = 2'b00,  // No external access
    CSLE   = 2'b01,  // Chip select leading edge
    STROBE = 2'b10,  // Read or write strobe active
    CSTE   = 2'b11   // Chip select trailing edge
  } smc_state_t;

  // ------------------------------
  // AHB transfer size
  // ------------------------------

  // Encoded as the low bits of hsize
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,  // 8 bit
    SIZE_HALF = 2'b01,  // 16 bit
    SIZE_WORD = 2'b10   // 32 bit, two EMI accesses
  } smc_size_t;

endpackage

/* smc_ahb_if.sv */
`timescale 1ns/1ps
`include "smc_defines.svh"

module smc_ahb_if import smc_pkg::*; (
  input  logic                    hclk,
  input  logic                    arst_n,
  input  logic                    hsel,        // Slave select
  input  logic                    hready,      // Muxed bus ready
  input  logic                    hwrite,
  input  logic [1:0]              htrans,
  input  logic [2:0]              hsize,
  input  logic [`SMC_HADDR_W-1:0] haddr,
  input  logic [`SMC_HDATA_W-1:0] hwdata,
  input  logic [`SMC_HDATA_W-1:0] read_data,   // Assembled by the MAC
  input  logic                    mac_done,    // Last cycle of last access
  output logic                    new_access,  // One cycle in the data phase
  output logic [`SMC_HADDR_W-1:0] addr,
  output smc_size_t               xfer_size,
  output logic                    n_read,      // Low for a read
  output logic [`SMC_HDATA_W-1:0] write_data,
  output logic [`SMC_HDATA_W-1:0] smc_hrdata,
  output logic                    smc_hready
);

  logic      addr_phase;  // Valid transfer seen on the bus
  smc_size_t size_dec;    // hsize folded to three sizes

  // NONSEQ or SEQ while the bus is ready
  assign addr_phase = hsel & htrans[1] & hready;

  // Sizes above a word are treated as a word
  always_comb begin
    if (hsize[2] | hsize[1]) begin
      size_dec = SIZE_WORD;
    end else if (hsize[0]) begin
      size_dec = SIZE_HALF;
    end else begin
      size_dec = SIZE_BYTE;
    end
  end

  // ------------------------------
  // Transfer attributes and stall
  // ------------------------------

  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      new_access <= 1'b0;
      xfer_size  <= SIZE_BYTE;
      n_read     <= 1'b1;
      smc_hready <= 1'b1;  // Ready when idle
    end else begin
      new_access <= addr_phase;  // Data phase follows next cycle
      if (addr_phase) begin
        xfer_size <= size_dec;
        n_read    <= hwrite;
      end
      // Stall the data phase until the MAC has finished
      if (addr_phase) begin
        smc_hready <= 1'b0;
      end else if (mac_done) begin
        smc_hready <= 1'b1;
      end
    end
  end

  // ------------------------------
  // Address and data registers
  // ------------------------------

  always_ff @(posedge hclk) begin
    if (addr_phase) begin
      addr <= haddr;
    end
    // hwdata is valid in the first data phase cycle
    if (new_access && n_read) begin
      write_data <= hwdata;
    end
    // Read data shows up together with hready
    if (mac_done && !n_read) begin
      smc_hrdata <= read_data;
    end
  end

endmodule

/* smc_timing.sv */
`timescale 1ns/1ps
`include "smc_defines.svh"

module smc_timing import smc_pkg::*; (
  input  logic       hclk,
  input  logic       arst_n,
  input  logic       new_access,   // First access of a transfer
  input  logic       more_access,  // Second half of a word
  output smc_state_t state,
  output logic       access_done,  // Last CSTE cycle
  output logic       sample_data   // Last strobe cycle
);

  // Counter reload values, each counts down to zero
  localparam logic [`SMC_CNT_W-1:0] CSLE_LOAD = `SMC_CNT_W'(`SMC_CSLE_CYCLES - 1);
  localparam logic [`SMC_CNT_W-1:0] WS_LOAD   = `SMC_CNT_W'(`SMC_WS_CYCLES);
  localparam logic [`SMC_CNT_W-1:0] CSTE_LOAD = `SMC_CNT_W'(`SMC_CSTE_CYCLES - 1);

  smc_state_t            next_state;
  logic [`SMC_CNT_W-1:0] csle_cnt;   // Leading edge
  logic [`SMC_CNT_W-1:0] ws_cnt;     // Wait states
  logic [`SMC_CNT_W-1:0] cste_cnt;   // Trailing edge
  logic                  start;
  logic                  csle_last;
  logic                  ws_last;
  logic                  cste_last;

  assign start     = new_access | more_access;
  assign csle_last = (csle_cnt == '0);
  assign ws_last   = (ws_cnt == '0);
  assign cste_last = (cste_cnt == '0);

  assign sample_data = (state == STROBE) & ws_last;
  assign access_done = (state == CSTE) & cste_last;

  // ------------------------------
  // Sequencer FSM
  // ------------------------------

  always_comb begin
    next_state = state;
    case (state)
      IDLE:    if (start)     next_state = CSLE;
      CSLE:    if (csle_last) next_state = STROBE;
      STROBE:  if (ws_last)   next_state = CSTE;
      CSTE:    if (cste_last) next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // ------------------------------
  // Phase counters
  // ------------------------------

  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      csle_cnt <= '0;
      ws_cnt   <= '0;
      cste_cnt <= '0;
    end else if (state == IDLE) begin
      if (start) begin  // Fresh timing for every access
        csle_cnt <= CSLE_LOAD;
        ws_cnt   <= WS_LOAD;
        cste_cnt <= CSTE_LOAD;
      end
    end else begin
      // Only the counter of the current phase moves
      if (state == CSLE && !csle_last) csle_cnt <= csle_cnt - 1'b1;
      if (state == STROBE && !ws_last) ws_cnt <= ws_cnt - 1'b1;
      if (state == CSTE && !cste_last) cste_cnt <= cste_cnt - 1'b1;
    end
  end

endmodule

/* smc_mac.sv */
`timescale 1ns/1ps
`include "smc_defines.svh"

module smc_mac import smc_pkg::*; (
  input  logic                      hclk,
  input  logic                      arst_n,
  input  logic                      new_access,
  input  logic [`SMC_HADDR_W-1:0]   addr,
  input  smc_size_t                 xfer_size,
  input  logic [`SMC_HDATA_W-1:0]   write_data,
  input  logic                      access_done,
  input  logic                      sample_data,
  input  logic [`SMC_EMI_DATA_W-1:0] data_smc,     // From the SRAM
  output logic                      more_access,  // Starts the second access
  output logic                      mac_done,
  output logic [`SMC_EMI_ADDR_W-1:0] emi_addr,
  output logic [`SMC_EMI_BE_W-1:0]   emi_lanes,    // Active high
  output logic [`SMC_EMI_DATA_W-1:0] emi_wdata,
  output logic [`SMC_HDATA_W-1:0]   read_data
);

  localparam int HW = `SMC_EMI_DATA_W;

  logic second;       // Access count, set for the upper half of a word
  logic is_word;
  logic hi_half;      // Upper AHB halfword in use
  logic last_access;

  assign is_word     = (xfer_size == SIZE_WORD);
  assign hi_half     = is_word ? second : addr[1];
  assign last_access = ~is_word | second;
  assign mac_done    = access_done & last_access;

  // ------------------------------
  // Access counting
  // ------------------------------

  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      second      <= 1'b0;
      more_access <= 1'b0;
    end else begin
      more_access <= access_done & ~last_access;  // One IDLE cycle between halves
      if (new_access) begin
        second <= 1'b0;
      end else if (access_done && !last_access) begin
        second <= 1'b1;
      end
    end
  end

  // ------------------------------
  // Address, lanes and write data
  // ------------------------------

  // Halfword aligned, bit 0 lives in the lanes
  assign emi_addr  = {addr[`SMC_HADDR_W-1:2], hi_half, 1'b0};
  assign emi_wdata = hi_half ? write_data[2*HW-1:HW] : write_data[HW-1:0];

  always_comb begin
    case (xfer_size)
      SIZE_BYTE: emi_lanes = addr[0] ? 2'b10 : 2'b01;
      default:   emi_lanes = 2'b11;  // Halfword or word half
    endcase
  end

  // Read halfword lands in the AHB lane it came from
  always_ff @(posedge hclk) begin
    if (sample_data) begin
      if (hi_half) begin
        read_data[2*HW-1:HW] <= data_smc;
      end else begin
        read_data[HW-1:0] <= data_smc;
      end
    end
  end

endmodule

/* smc_strobe.sv */
`timescale 1ns/1ps
`include "smc_defines.svh"

module smc_strobe import smc_pkg::*; (
  input  logic                       hclk,
  input  logic                       arst_n,
  input  smc_state_t                 state,
  input  logic                       n_read,
  input  logic [`SMC_EMI_ADDR_W-1:0] emi_addr,
  input  logic [`SMC_EMI_BE_W-1:0]   emi_lanes,
  input  logic [`SMC_EMI_DATA_W-1:0] emi_wdata,
  output logic [`SMC_EMI_ADDR_W-1:0] smc_addr,
  output logic [`SMC_EMI_DATA_W-1:0] smc_data,
  output logic [`SMC_EMI_BE_W-1:0]   smc_n_be,
  output logic                       smc_n_cs,
  output logic                       smc_n_rd,
  output logic                       smc_n_wr,
  output logic [`SMC_EMI_BE_W-1:0]   smc_n_we,
  output logic                       smc_n_ext_oe,
  output logic                       smc_busy
);

  logic cs_on;      // Any phase of an access
  logic strobe_on;
  logic wr_strobe;

  assign cs_on     = (state != IDLE);
  assign strobe_on = (state == STROBE);
  assign wr_strobe = strobe_on & n_read;

  // ------------------------------
  // Registered pins
  // ------------------------------

  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      smc_n_cs     <= 1'b1;
      smc_n_rd     <= 1'b1;
      smc_n_wr     <= 1'b1;
      smc_n_we     <= '1;
      smc_n_be     <= '1;
      smc_n_ext_oe <= 1'b1;
      smc_busy     <= 1'b0;
    end else begin
      smc_n_cs     <= ~cs_on;
      smc_n_rd     <= ~(strobe_on & ~n_read);
      smc_n_wr     <= ~wr_strobe;
      smc_n_we     <= wr_strobe ? ~emi_lanes : '1;  // Per lane write strobe
      smc_n_be     <= cs_on ? ~emi_lanes : '1;
      smc_n_ext_oe <= ~(cs_on & n_read);            // Drive data through CS on writes
      smc_busy     <= cs_on;
    end
  end

  always_ff @(posedge hclk) begin
    smc_addr <= emi_addr;
    smc_data <= emi_wdata;
  end

endmodule

/* smc_lite.sv */
`timescale 1ns/1ps
`include "smc_defines.svh"

module smc_lite import smc_pkg::*; (
  input  logic                       hclk,
  input  logic                       arst_n,
  input  logic                       hsel,
  input  logic                       hready,
  input  logic                       hwrite,
  input  logic [1:0]                 htrans,
  input  logic [2:0]                 hsize,
  input  logic [`SMC_HADDR_W-1:0]    haddr,
  input  logic [`SMC_HDATA_W-1:0]    hwdata,
  input  logic [`SMC_EMI_DATA_W-1:0] data_smc,
  output logic [`SMC_HDATA_W-1:0]    smc_hrdata,
  output logic                       smc_hready,
  output logic [`SMC_EMI_ADDR_W-1:0] smc_addr,
  output logic [`SMC_EMI_DATA_W-1:0] smc_data,
  output logic [`SMC_EMI_BE_W-1:0]   smc_n_be,
  output logic                       smc_n_cs,
  output logic                       smc_n_rd,
  output logic                       smc_n_wr,
  output logic [`SMC_EMI_BE_W-1:0]   smc_n_we,
  output logic                       smc_n_ext_oe,
  output logic                       smc_busy
);

  // Bus front end
  logic                       new_access;
  logic [`SMC_HADDR_W-1:0]    addr;
  smc_size_t                  xfer_size;
  logic                       n_read;
  logic [`SMC_HDATA_W-1:0]    write_data;
  // Sequencer
  smc_state_t                 state;
  logic                       access_done;
  logic                       sample_data;
  // Access splitter
  logic                       more_access;
  logic                       mac_done;
  logic [`SMC_EMI_ADDR_W-1:0] emi_addr;
  logic [`SMC_EMI_BE_W-1:0]   emi_lanes;
  logic [`SMC_EMI_DATA_W-1:0] emi_wdata;
  logic [`SMC_HDATA_W-1:0]    read_data;

  smc_ahb_if u_ahb_if (
    .hclk       (hclk),
    .arst_n     (arst_n),
    .hsel       (hsel),
    .hready     (hready),
    .hwrite     (hwrite),
    .htrans     (htrans),
    .hsize      (hsize),
    .haddr      (haddr),
    .hwdata     (hwdata),
    .read_data  (read_data),
    .mac_done   (mac_done),
    .new_access (new_access),
    .addr       (addr),
    .xfer_size  (xfer_size),
    .n_read     (n_read),
    .write_data (write_data),
    .smc_hrdata (smc_hrdata),
    .smc_hready (smc_hready)
  );

  smc_timing u_timing (
    .hclk        (hclk),
    .arst_n      (arst_n),
    .new_access  (new_access),
    .more_access (more_access),
    .state       (state),
    .access_done (access_done),
    .sample_data (sample_data)
  );

  smc_mac u_mac (
    .hclk        (hclk),
    .arst_n      (arst_n),
    .new_access  (new_access),
    .addr        (addr),
    .xfer_size   (xfer_size),
    .write_data  (write_data),
    .access_done (access_done),
    .sample_data (sample_data),
    .data_smc    (data_smc),
    .more_access (more_access),
    .mac_done    (mac_done),
    .emi_addr    (emi_addr),
    .emi_lanes   (emi_lanes),
    .emi_wdata   (emi_wdata),
    .read_data   (read_data)
  );

  smc_strobe u_strobe (
    .hclk         (hclk),
    .arst_n       (arst_n),
    .state        (state),
    .n_read       (n_read),
    .emi_addr     (emi_addr),
    .emi_lanes    (emi_lanes),
    .emi_wdata    (emi_wdata),
    .smc_addr     (smc_addr),
    .smc_data     (smc_data),
    .smc_n_be     (smc_n_be),
    .smc_n_cs     (smc_n_cs),
    .smc_n_rd     (smc_n_rd),
    .smc_n_wr     (smc_n_wr),
    .smc_n_we     (smc_n_we),
    .smc_n_ext_oe (smc_n_ext_oe),
    .smc_busy     (smc_busy)
  );

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic hclk,
  output logic arst_n
);

  localparam int RST_CYCLES = 16;

  initial hclk = 1'b0;
  always #50 hclk = ~hclk;  // 100 ns period

  // Reset held for the first cycles, released on an edge
  initial begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge hclk);
    arst_n <= 1'b1;
  end

endmodule

/* tb_sram.sv */
`timescale 1ns/1ps

module tb_sram (
  input  logic [31:0] smc_addr,
  input  logic [15:0] smc_data,
  input  logic [1:0]  smc_n_we,
  input  logic        smc_n_rd,
  input  logic        smc_n_cs,
  output logic [15:0] data_smc
);

  logic [15:0] mem [0:127];  // 256 bytes, halfword wide

  // Start pattern, one byte per address
  function automatic logic [7:0] fill_byte(input int b);
    return 8'((b * 37 + 11) & 8'hff);
  endfunction

  initial begin
    for (int i = 0; i < 128; i++) begin
      mem[i] = {fill_byte(2 * i + 1), fill_byte(2 * i)};
    end
  end

  // Lanes written on the trailing edge of their strobe
  always @(posedge smc_n_we[0]) if (!smc_n_cs) mem[smc_addr[7:1]][7:0] <= smc_data[7:0];
  always @(posedge smc_n_we[1]) if (!smc_n_cs) mem[smc_addr[7:1]][15:8] <= smc_data[15:8];

  assign data_smc = smc_n_rd ? 16'hxxxx : mem[smc_addr[7:1]];  // Drive only while read strobe low

endmodule

/* tb_smc_lite.sv */
`timescale 1ns/1ps
`include "smc_defines.svh"

module tb_smc_lite;

  localparam int N_PAIRS = 4;
  localparam int N_RAND  = 40;
  localparam int N_XFER  = 2 * N_PAIRS + N_RAND;
  localparam int TIMEOUT = N_XFER * 12 + 100;
  localparam int CSLE    = `SMC_CSLE_CYCLES;
  localparam int STB_LEN = `SMC_WS_CYCLES + 1;
  localparam int CSTE    = `SMC_CSTE_CYCLES;
  localparam int CS_LEN  = CSLE + STB_LEN + CSTE;

  logic        hclk, arst_n, hsel, hready, hwrite;
  logic [1:0]  htrans;
  logic [2:0]  hsize;
  logic [31:0] haddr, hwdata, smc_hrdata, smc_addr;
  logic [15:0] data_smc, smc_data;
  logic [1:0]  smc_n_be, smc_n_we;
  logic        smc_hready, smc_n_cs, smc_n_rd, smc_n_wr, smc_n_ext_oe, smc_busy;

  logic [15:0] lfsr;
  logic [7:0]  ref_mem [0:255];  // Reference bytes
  logic [31:0] cs_addr_q [$];    // smc_addr at each chip select start
  logic [1:0]  exp_lanes;
  logic        writing_now, stb_done, strobe_low;
  int          cs_cnt, stb_cnt, post_cnt, cycles;

  assign hready = smc_hready;  // Single slave on the bus

  tb_clock u_clock (.hclk(hclk), .arst_n(arst_n));

  tb_sram u_sram (.smc_addr(smc_addr), .smc_data(smc_data), .smc_n_we(smc_n_we),
                  .smc_n_rd(smc_n_rd), .smc_n_cs(smc_n_cs), .data_smc(data_smc));

  smc_lite dut (
    .hclk(hclk), .arst_n(arst_n), .hsel(hsel), .hready(hready), .hwrite(hwrite),
    .htrans(htrans), .hsize(hsize), .haddr(haddr), .hwdata(hwdata), .data_smc(data_smc),
    .smc_hrdata(smc_hrdata), .smc_hready(smc_hready), .smc_addr(smc_addr),
    .smc_data(smc_data), .smc_n_be(smc_n_be), .smc_n_cs(smc_n_cs), .smc_n_rd(smc_n_rd),
    .smc_n_wr(smc_n_wr), .smc_n_we(smc_n_we), .smc_n_ext_oe(smc_n_ext_oe),
    .smc_busy(smc_busy)
  );

  task automatic report_fail(input string msg);
    $display("FAIL @ %0t ns: %s", $time, msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};  // One step per bit
    end
  endtask

  // ------------------------------
  // AHB master
  // ------------------------------

  task automatic ahb_xfer(input logic wr, input logic [1:0] sz, input logic [31:0] a,
                          input logic [31:0] wd, output logic [31:0] rd);
    logic [31:0] base;
    @(posedge hclk);
    cs_addr_q.delete();
    writing_now = wr;
    exp_lanes   = (sz == 2'd0) ? (a[0] ? 2'b10 : 2'b01) : 2'b11;
    hsel   <= 1'b1;  // Address phase
    htrans <= 2'b10;
    hwrite <= wr;
    hsize  <= {1'b0, sz};
    haddr  <= a;
    @(posedge hclk);
    hsel   <= 1'b0;  // Data phase
    htrans <= 2'b00;
    hwdata <= wd;
    @(negedge hclk);
    assert (!smc_hready) else report_fail("hready not low in the data phase");
    while (!smc_hready) @(negedge hclk);
    rd = smc_hrdata;
    base = (sz == 2'd2) ? {a[31:2], 2'b00} : {a[31:1], 1'b0};
    assert (cs_addr_q.size() == ((sz == 2'd2) ? 2 : 1))
      else report_fail("wrong number of chip select periods");
    assert (cs_addr_q[0] == base) else report_fail("first EMI address wrong");
    if (sz == 2'd2) begin
      assert (cs_addr_q[1] == base + 2) else report_fail("second EMI address wrong");
    end
  endtask

  // Write merges into the reference, read compares active lanes
  task automatic do_access(input logic wr, input logic [1:0] sz, input logic [31:0] a,
                           input logic [31:0] wd);
    logic [31:0] rd;
    logic [7:0]  b;
    ahb_xfer(wr, sz, a, wd, rd);
    for (int i = 0; i < (1 << sz); i++) begin
      b = a[7:0] + 8'(i);
      if (wr) ref_mem[b] = wd[8 * b[1:0] +: 8];
      else assert (rd[8 * b[1:0] +: 8] == ref_mem[b])
        else report_fail($sformatf("read byte %0h got %0h", b, rd[8 * b[1:0] +: 8]));
    end
  endtask

  // ------------------------------
  // EMI pin monitor
  // ------------------------------

  always @(negedge hclk) begin
    if (arst_n) begin
      strobe_low = !smc_n_rd || !smc_n_wr || (smc_n_we != 2'b11);
      assert (smc_busy == !smc_n_cs) else report_fail("smc_busy does not follow chip select");
      assert (smc_n_ext_oe == (smc_n_cs || !writing_now)) else report_fail("ext_oe wrong");
      if (strobe_low) begin
        if (stb_cnt == 0) begin
          assert (!smc_n_cs && cs_cnt == CSLE) else report_fail("strobe lead wrong");
        end
        assert (smc_n_rd == writing_now && smc_n_wr == !writing_now)
          else report_fail("strobe of wrong direction");
        if (writing_now) begin
          assert (smc_n_we == ~exp_lanes && smc_n_be == ~exp_lanes)
            else report_fail("write lanes wrong");
        end
        assert (!smc_hready) else report_fail("hready high during strobe");
        stb_cnt++;
      end else if (stb_cnt != 0) begin
        assert (stb_cnt == STB_LEN) else report_fail("strobe length wrong");
        stb_cnt  = 0;
        stb_done = 1'b1;
      end
      if (!smc_n_cs) begin
        if (cs_cnt == 0) cs_addr_q.push_back(smc_addr);  // Chip select start
        if (stb_done) post_cnt++;
        else assert (!smc_hready) else report_fail("hready high before strobe end");
        cs_cnt++;
      end else if (cs_cnt != 0) begin
        assert (cs_cnt == CS_LEN && post_cnt == CSTE) else report_fail("chip select period wrong");
        cs_cnt   = 0;
        post_cnt = 0;
        stb_done = 1'b0;
      end
    end
  end

  // Run length guard
  always @(posedge hclk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("CHECKS FAILED");
      $fatal(1, "timeout");
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------

  initial begin
    logic [31:0] a, d, s, w;
    hsel = 1'b0;
    hwrite = 1'b0;
    htrans = 2'b00;
    hsize = 3'd0;
    haddr = '0;
    hwdata = '0;
    lfsr = 16'd55975;
    writing_now = 1'b0;
    exp_lanes = 2'b11;
    stb_done = 1'b0;
    cs_cnt = 0;
    stb_cnt = 0;
    post_cnt = 0;
    cycles = 0;
    for (int i = 0; i < 256; i++) ref_mem[i] = 8'((i * 37 + 11) & 8'hff);  // SRAM start pattern
    wait (arst_n);
    @(negedge hclk);
    assert (smc_n_cs && smc_n_rd && smc_n_wr && smc_n_we == 2'b11 && smc_n_ext_oe
            && !smc_busy && smc_hready) else report_fail("EMI pins not idle after reset");
    // Word write then word read back
    for (int i = 0; i < N_PAIRS; i++) begin
      rand_bits(6, a);
      rand_bits(32, d);
      a = 32'h1000_0000 | {a[29:0], 2'b00};
      do_access(1'b1, 2'd2, a, d);
      do_access(1'b0, 2'd2, a, 32'h0);
    end
    // Mixed sizes and directions
    for (int i = 0; i < N_RAND; i++) begin
      rand_bits(2, s);
      if (s == 3) s = 2;  // Word weighted double
      rand_bits(8, a);
      a = 32'h1000_0000 | (a & ~((32'd1 << s[1:0]) - 1));
      rand_bits(32, d);
      rand_bits(1, w);
      do_access(w[0], s[1:0], a, d);
    end
    // Let the monitor close the last chip select period
    repeat (2) @(negedge hclk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+.
smc_pkg.sv
smc_ahb_if.sv
smc_timing.sv
smc_mac.sv
smc_strobe.sv
smc_lite.sv
tb_clock.sv
tb_sram.sv
tb_smc_lite.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_smc_lite -o sim_smc
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

./obj_dir/sim_smc
if [ $? -ne 0 ]; then
  echo "Simulation failed"
  exit 1
fi

exit 0
